// ==== vlog.f ====
common/decode_pkg.sv
common/regfile_read_if.sv
decode/instr_decoder.sv
decode/imm_gen.sv
regfile/register_file.sv
source/operand_forward.sv
source/decode_pipe_reg.sv
source/decode_stage.sv
verification/decode_stage_props.sv
verification/decode_stage_tb.sv

// ==== verification/decode_stage_tb.sv ====
// Self-checking testbench for decode_stage: random and directed stimulus against a reference model
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          TIMEOUT_CYCLES = 20;
    localparam logic [31:0] SEED           = 32'hd7e3_bb2e;

    typedef struct packed {
        op_e        op;
        word_t      val1;
        word_t      val2;
        word_t      store_data;
        cmp_flags_t cmp;
        reg_addr_t  rd;
        pc_t        pc_plus4;
    } stage_out_t;

    logic       clk;
    logic       rst;
    instr_t     instr;
    pc_t        pc;
    pc_t        pc_plus4;
    word_t      exec_fwd;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       wb_we;
    logic       stall;
    logic       flush;
    fwd_sel_e   fwd1_sel;
    fwd_sel_e   fwd2_sel;
    op_e        op_out;
    word_t      val1_out;
    word_t      val2_out;
    word_t      store_out;
    cmp_flags_t cmp_out;
    reg_addr_t  rd_out;
    pc_t        pc4_out;
    reg_addr_t  rs1_out;
    reg_addr_t  rs2_out;

    word_t      model_regs [NUM_REGS];
    stage_out_t exp_out;
    logic       started     = 1'b0; // First reset edge seen
    logic       loaded      = 1'b0; // Data fields hold a known value
    int         checks_done = 0;

    decode_stage dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .instr_i      (instr),
        .pc_i         (pc),
        .pc_plus4_i   (pc_plus4),
        .exec_fwd_i   (exec_fwd),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .wb_we_i      (wb_we),
        .stall_i      (stall),
        .flush_i      (flush),
        .fwd1_sel_i   (fwd1_sel),
        .fwd2_sel_i   (fwd2_sel),
        .op_o         (op_out),
        .val1_o       (val1_out),
        .val2_o       (val2_out),
        .store_data_o (store_out),
        .cmp_o        (cmp_out),
        .rd_addr_o    (rd_out),
        .pc_plus4_o   (pc4_out),
        .rs1_addr_o   (rs1_out),
        .rs2_addr_o   (rs2_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic op_e expected_op(input instr_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       reg_form;
        logic       f7_checked;
        f3         = ins[14:12];
        f7         = ins[31:25];
        reg_form   = (ins[6:2] == OPC_OP);
        f7_checked = reg_form || (f3 == 3'd1) || (f3 == 3'd5); // Immediate forms: shifts only
        if (ins[1:0] != 2'b11) return OP_ILLEGAL;
        case (ins[6:2])
            OPC_OP, OPC_OP_IMM: begin
                if (f7_checked && f7 == 7'h20 && f3 == 3'd5) return OP_SRA;
                if (f7_checked && f7 == 7'h20 && f3 == 3'd0 && reg_form) return OP_SUB;
                if (f7_checked && f7 != 7'h00) return OP_ILLEGAL;
                case (f3)
                    3'd0:    return OP_ADD;
                    3'd1:    return OP_SLL;
                    3'd2:    return OP_SLT;
                    3'd3:    return OP_SLTU;
                    3'd4:    return OP_XOR;
                    3'd5:    return OP_SRL;
                    3'd6:    return OP_OR;
                    default: return OP_AND;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0:    return OP_LB;
                    3'd1:    return OP_LH;
                    3'd2:    return OP_LW;
                    3'd4:    return OP_LBU;
                    3'd5:    return OP_LHU;
                    default: return OP_ILLEGAL;
                endcase
            end
            OPC_STORE: return (f3 == 3'd0) ? OP_SB : (f3 == 3'd1) ? OP_SH :
                              (f3 == 3'd2) ? OP_SW : OP_ILLEGAL;
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    return OP_BEQ;
                    3'd1:    return OP_BNE;
                    3'd4:    return OP_BLT;
                    3'd5:    return OP_BGE;
                    3'd6:    return OP_BLTU;
                    3'd7:    return OP_BGEU;
                    default: return OP_ILLEGAL;
                endcase
            end
            OPC_JALR:  return (f3 == 3'd0) ? OP_JALR : OP_ILLEGAL;
            OPC_JAL:   return OP_JAL;
            OPC_LUI:   return OP_LUI;
            OPC_AUIPC: return OP_AUIPC;
            default:   return OP_ILLEGAL;
        endcase
    endfunction

    function automatic word_t expected_imm(input instr_t ins);
        logic [11:0] i12;
        logic [11:0] s12;
        logic [12:0] b13;
        logic [20:0] j21;
        i12 = ins[31:20];
        s12 = {ins[31:25], ins[11:7]};
        b13 = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        j21 = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        case (ins[6:2])
            OPC_STORE:          return {{20{s12[11]}}, s12};
            OPC_BRANCH:         return {{19{b13[12]}}, b13};
            OPC_JAL:            return {{11{j21[20]}}, j21};
            OPC_LUI, OPC_AUIPC: return {ins[31:12], 12'h000};
            default:            return {{20{i12[11]}}, i12};
        endcase
    endfunction

    // Expected stage register contents for one set of inputs, old register file contents
    function automatic stage_out_t predict(input instr_t ins, input pc_t pc_v, input pc_t pc4_v,
                                           input fwd_sel_e s1, input fwd_sel_e s2,
                                           input word_t ex_v, input word_t wb_v);
        stage_out_t r;
        word_t      a;
        word_t      b;
        logic       uses_pc;
        logic       uses_imm;
        a = (s1 == FWD_EXEC) ? ex_v : (s1 == FWD_WB) ? wb_v : model_regs[ins[19:15]];
        b = (s2 == FWD_EXEC) ? ex_v : (s2 == FWD_WB) ? wb_v : model_regs[ins[24:20]];
        r.op     = expected_op(ins);
        uses_pc  = (r.op != OP_ILLEGAL) && (ins[6:2] inside {OPC_BRANCH, OPC_JAL, OPC_AUIPC});
        uses_imm = (r.op != OP_ILLEGAL) && (ins[6:2] != OPC_OP);
        r.val1       = uses_pc ? {pc_v, 1'b0} : a;
        r.val2       = uses_imm ? expected_imm(ins) : b;
        r.store_data = b;
        r.cmp        = {$signed(a) < $signed(b), a < b, a == b};
        r.rd         = ins[11:7];
        r.pc_plus4   = pc4_v;
        return r;
    endfunction

    // Random encoding of one legal kind: 0 R-type, then OP-IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC
    function automatic instr_t random_legal(input int kind);
        instr_t x;
        x = $urandom;
        case (kind)
            0: begin
                x[6:2]   = OPC_OP;
                x[31:25] = (x[31] && (x[14:12] inside {3'd0, 3'd5})) ? 7'h20 : 7'h00;
            end
            1: begin
                x[6:2] = OPC_OP_IMM;
                if (x[14:12] == 3'd1) x[31:25] = 7'h00;
                if (x[14:12] == 3'd5) x[31:25] = x[31] ? 7'h20 : 7'h00; // SRAI or SRLI
            end
            2: begin
                x[6:2] = OPC_LOAD;
                if (x[14:12] inside {3'd3, 3'd6, 3'd7}) x[14:12] = 3'd2;
            end
            3: begin
                x[6:2] = OPC_STORE;
                if (x[14:12] > 3'd2) x[14:12] = 3'd2;
            end
            4: begin
                x[6:2] = OPC_BRANCH;
                if (x[14:12] inside {3'd2, 3'd3}) x[14:12] = 3'd0;
            end
            5: x[6:2] = OPC_JAL;
            6: begin
                x[6:2]   = OPC_JALR;
                x[14:12] = 3'd0;
            end
            7: x[6:2] = OPC_LUI;
            default: x[6:2] = OPC_AUIPC;
        endcase
        x[1:0] = 2'b11;
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_flag_pair(input word_t a, input word_t b);
        instr    = random_legal(4);
        fwd1_sel = FWD_EXEC; // a on rs1, b on rs2
        fwd2_sel = FWD_WB;
        exec_fwd = a;
        wb_data  = b;
        next_cycle();
    endtask

    // Lets the last driven inputs reach the outputs and be compared
    task automatic wait_for_checks();
        int target;
        target = checks_done + 2;
        for (int t = 0; t < TIMEOUT_CYCLES && checks_done < target; t++) begin
            @(posedge clk);
        end
        if (checks_done < target) begin
            $display("Timeout: the compare process stopped advancing");
            $display("Test failed");
            $fatal(1, "Compare process timeout");
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_out.op  = OP_NOP;
            exp_out.cmp = '0;
            started     = 1'b1;
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (!stall) begin
                exp_out = predict(instr, pc, pc_plus4, fwd1_sel, fwd2_sel, exec_fwd, wb_data);
                if (flush) exp_out.op = OP_NOP;
                loaded = 1'b1;
            end
            if (wb_we && wb_addr != '0) model_regs[wb_addr] = wb_data; // After the read
        end
    end

    always @(negedge clk) begin
        if (started) begin
            check("op_o", op_out, exp_out.op);
            check("cmp_o", cmp_out, exp_out.cmp);
            if (loaded) begin
                check("val1_o", val1_out, exp_out.val1);
                check("val2_o", val2_out, exp_out.val2);
                check("store_data_o", store_out, exp_out.store_data);
                check("rd_addr_o", rd_out, exp_out.rd);
                check("pc_plus4_o", pc4_out, exp_out.pc_plus4);
            end
            check("rs1_addr_o", rs1_out, instr[19:15]);
            check("rs2_addr_o", rs2_out, instr[24:20]);
            if (dut_i.u_props.fail_count != 0) begin
                $display("A bound assertion on the stage register failed");
                $display("Test failed");
                $fatal(1, "Assertion failure");
            end
            checks_done++;
        end
    end

    initial begin
        instr_t x;
        void'($urandom(SEED));
        rst      = 1'b1;
        instr    = '0;
        pc       = '0;
        pc_plus4 = '0;
        exec_fwd = '0;
        wb_addr  = '0;
        wb_data  = '0;
        wb_we    = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        fwd1_sel = FWD_NONE;
        fwd2_sel = FWD_NONE;
        repeat (4) next_cycle();
        rst = 1'b0;

        // Register file writes, read back through ADD and SUB
        for (int n = 0; n < 48; n++) begin
            x        = random_legal(0);
            x[14:12] = 3'd0;
            x[31:25] = (n % 2) ? 7'h20 : 7'h00;
            wb_we    = (n < 40);
            wb_addr  = reg_addr_t'($urandom_range(0, 31));
            wb_data  = $urandom;
            if (n % 4 == 1) x[19:15] = wb_addr; // Same-cycle read returns the old value
            instr    = x;
            pc       = pc_t'($urandom);
            pc_plus4 = pc + 31'd2;
            next_cycle();
        end
        wb_we   = 1'b1; // x0 must stay zero
        wb_addr = '0;
        wb_data = 32'hdead_beef;
        next_cycle();
        wb_we        = 1'b0;
        instr[19:15] = '0;
        instr[24:20] = '0;
        next_cycle();

        // Each immediate format with its operand choice
        for (int k = 1; k <= 8; k++) begin
            for (int n = 0; n < 3; n++) begin
                instr    = random_legal(k);
                pc       = pc_t'($urandom);
                pc_plus4 = pc + 31'd2;
                next_cycle();
            end
        end

        // Forwarding, spare select code included
        for (int n = 0; n < 40; n++) begin
            instr    = random_legal($urandom_range(0, 8));
            fwd1_sel = fwd_sel_e'($urandom_range(0, 3));
            fwd2_sel = fwd_sel_e'($urandom_range(0, 3));
            exec_fwd = $urandom;
            wb_we    = ($urandom_range(0, 1) == 1);
            wb_addr  = reg_addr_t'($urandom_range(0, 31));
            wb_data  = $urandom;
            next_cycle();
        end
        wb_we = 1'b0;

        drive_flag_pair(32'h8000_0000, 32'h0000_0001); // Signed less, unsigned greater
        drive_flag_pair(32'h0000_0005, 32'hffff_fffb);
        drive_flag_pair(32'h1234_5678, 32'h1234_5678);
        drive_flag_pair(32'hffff_fff0, 32'h0000_0010);
        drive_flag_pair(32'h0000_0001, 32'h0000_0002);

        // Random stall and flush
        for (int n = 0; n < 40; n++) begin
            instr    = random_legal($urandom_range(0, 8));
            fwd1_sel = fwd_sel_e'($urandom_range(0, 3));
            fwd2_sel = fwd_sel_e'($urandom_range(0, 3));
            exec_fwd = $urandom;
            pc       = pc_t'($urandom);
            pc_plus4 = pc + 31'd2;
            stall    = ($urandom_range(0, 3) == 0);
            flush    = ($urandom_range(0, 2) == 0);
            next_cycle();
        end
        stall = 1'b1; // Stall wins over flush
        flush = 1'b1;
        instr = random_legal(1);
        next_cycle();
        stall = 1'b0;
        next_cycle();
        flush = 1'b0;
        rst   = 1'b1; // Reset with traffic and a stall pending
        stall = 1'b1;
        repeat (2) next_cycle();
        rst   = 1'b0;
        stall = 1'b0;

        // Encodings outside the kept subset
        for (int n = 0; n < 30; n++) begin
            x = $urandom;
            case (n % 3)
                0: x[1:0] = 2'($urandom_range(0, 2)); // Compressed space
                1: x[6:0] = 7'b1110011;                // SYSTEM
                default: begin
                    x[6:0]   = 7'b0110011;             // M extension funct7
                    x[31:25] = 7'b0000001;
                end
            endcase
            instr    = x;
            fwd1_sel = fwd_sel_e'($urandom_range(0, 3));
            fwd2_sel = fwd_sel_e'($urandom_range(0, 3));
            next_cycle();
        end

        wait_for_checks();
        if (dut_i.u_props.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Bound assertion failures");
        end
    end

endmodule

// ==== verification/decode_stage_props.sv ====
// Concurrent checks on the decode stage output register, bound into decode_stage
`timescale 1ns/1ps

module decode_stage_props (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   stall_i,
    input logic                   flush_i,
    input decode_pkg::op_e        op_i,
    input decode_pkg::word_t      val1_i,
    input decode_pkg::word_t      val2_i,
    input decode_pkg::word_t      store_data_i,
    input decode_pkg::cmp_flags_t cmp_i,
    input decode_pkg::reg_addr_t  rd_addr_i,
    input decode_pkg::pc_t        pc_plus4_i
);
    import decode_pkg::*;

    int fail_count = 0; // Polled by the testbench

    reset_clears: assert property (@(posedge clk_i) rst_i |=> (op_i == OP_NOP) && (cmp_i == '0))
        else begin
            $error("op_o or cmp_o not cleared by reset");
            fail_count++;
        end

    stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable({op_i, val1_i, val2_i, store_data_i, cmp_i, rd_addr_i, pc_plus4_i}))
        else begin
            $error("Stage register changed during a stall");
            fail_count++;
        end

    flush_gives_nop: assert property (@(posedge clk_i) disable iff (rst_i)
        (flush_i && !stall_i) |=> (op_i == OP_NOP))
        else begin
            $error("Flush without stall did not load OP_NOP");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_props u_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .op_i         (op_o),
    .val1_i       (val1_o),
    .val2_i       (val2_o),
    .store_data_i (store_data_o),
    .cmp_i        (cmp_o),
    .rd_addr_i    (rd_addr_o),
    .pc_plus4_i   (pc_plus4_o)
);

// ==== source/decode_stage.sv ====
// Decode and register-read stage top; connects decoder, register file, operands and stage register
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  decode_pkg::instr_t     instr_i,
    input  decode_pkg::pc_t        pc_i,
    input  decode_pkg::pc_t        pc_plus4_i,
    input  decode_pkg::word_t      exec_fwd_i,
    input  decode_pkg::reg_addr_t  wb_addr_i,
    input  decode_pkg::word_t      wb_data_i,
    input  logic                   wb_we_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  decode_pkg::fwd_sel_e   fwd1_sel_i,
    input  decode_pkg::fwd_sel_e   fwd2_sel_i,
    output decode_pkg::op_e        op_o,
    output decode_pkg::word_t      val1_o,
    output decode_pkg::word_t      val2_o,
    output decode_pkg::word_t      store_data_o,
    output decode_pkg::cmp_flags_t cmp_o,
    output decode_pkg::reg_addr_t  rd_addr_o,
    output decode_pkg::pc_t        pc_plus4_o,
    output decode_pkg::reg_addr_t  rs1_addr_o,
    output decode_pkg::reg_addr_t  rs2_addr_o
);
    import decode_pkg::*;

    op_e        dec_op;
    opsel_e     dec_opsel;
    word_t      imm;
    word_t      val1;
    word_t      val2;
    word_t      store_data;
    cmp_flags_t cmp;

    regfile_read_if rf_if ();

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .op_o    (dec_op),
        .opsel_o (dec_opsel)
    );

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm)
    );

    register_file u_regfile (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_port   (rf_if),
        .wr_addr_i (wb_addr_i),
        .wr_data_i (wb_data_i),
        .wr_en_i   (wb_we_i)
    );

    operand_forward u_operands (
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .imm_i        (imm),
        .opsel_i      (dec_opsel),
        .fwd1_sel_i   (fwd1_sel_i),
        .fwd2_sel_i   (fwd2_sel_i),
        .exec_fwd_i   (exec_fwd_i),
        .wb_data_i    (wb_data_i), // Same value that writes the register file
        .rf           (rf_if),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .val1_o       (val1),
        .val2_o       (val2),
        .store_data_o (store_data),
        .cmp_o        (cmp)
    );

    decode_pipe_reg u_pipe_reg (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .op_i         (dec_op),
        .val1_i       (val1),
        .val2_i       (val2),
        .store_data_i (store_data),
        .cmp_i        (cmp),
        .rd_addr_i    (instr_i[11:7]), // rd field
        .pc_plus4_i   (pc_plus4_i),
        .op_o         (op_o),
        .val1_o       (val1_o),
        .val2_o       (val2_o),
        .store_data_o (store_data_o),
        .cmp_o        (cmp_o),
        .rd_addr_o    (rd_addr_o),
        .pc_plus4_o   (pc_plus4_o)
    );

endmodule

// ==== source/decode_pipe_reg.sv ====
// Decode to execute pipeline register with reset, stall hold and flush to NOP
`timescale 1ns/1ps

module decode_pipe_reg (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  decode_pkg::op_e        op_i,
    input  decode_pkg::word_t      val1_i,
    input  decode_pkg::word_t      val2_i,
    input  decode_pkg::word_t      store_data_i,
    input  decode_pkg::cmp_flags_t cmp_i,
    input  decode_pkg::reg_addr_t  rd_addr_i,
    input  decode_pkg::pc_t        pc_plus4_i,
    output decode_pkg::op_e        op_o,
    output decode_pkg::word_t      val1_o,
    output decode_pkg::word_t      val2_o,
    output decode_pkg::word_t      store_data_o,
    output decode_pkg::cmp_flags_t cmp_o,
    output decode_pkg::reg_addr_t  rd_addr_o,
    output decode_pkg::pc_t        pc_plus4_o
);
    import decode_pkg::*;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_o  <= OP_NOP;
            cmp_o <= '0;
        end else if (!stall_i) begin // Stall wins over flush
            op_o         <= flush_i ? OP_NOP : op_i;
            val1_o       <= val1_i;
            val2_o       <= val2_i;
            store_data_o <= store_data_i;
            cmp_o        <= cmp_i;
            rd_addr_o    <= rd_addr_i;
            pc_plus4_o   <= pc_plus4_i; // Link value for JAL and JALR
        end
    end

endmodule

// ==== source/operand_forward.sv ====
// Register read, forwarding, PC or immediate operand choice and branch compare flags
`timescale 1ns/1ps

module operand_forward (
    input  decode_pkg::instr_t     instr_i,
    input  decode_pkg::pc_t        pc_i,
    input  decode_pkg::word_t      imm_i,
    input  decode_pkg::opsel_e     opsel_i,
    input  decode_pkg::fwd_sel_e   fwd1_sel_i,
    input  decode_pkg::fwd_sel_e   fwd2_sel_i,
    input  decode_pkg::word_t      exec_fwd_i,
    input  decode_pkg::word_t      wb_data_i,
    regfile_read_if.client         rf,
    output decode_pkg::reg_addr_t  rs1_addr_o,
    output decode_pkg::reg_addr_t  rs2_addr_o,
    output decode_pkg::word_t      val1_o,
    output decode_pkg::word_t      val2_o,
    output decode_pkg::word_t      store_data_o,
    output decode_pkg::cmp_flags_t cmp_o
);
    import decode_pkg::*;

    word_t fwd1;
    word_t fwd2;
    logic  sel_pc;
    logic  sel_imm;

    function automatic word_t pick_source(input fwd_sel_e sel, input word_t rf_val,
                                          input word_t ex_val, input word_t wb_val);
        case (sel)
            FWD_EXEC: return ex_val;
            FWD_WB:   return wb_val;
            default:  return rf_val; // FWD_NONE and the spare code
        endcase
    endfunction

    assign rf.rs1_addr = instr_i[19:15];
    assign rf.rs2_addr = instr_i[24:20];
    assign rs1_addr_o  = instr_i[19:15]; // To hazard unit
    assign rs2_addr_o  = instr_i[24:20];

    assign fwd1 = pick_source(fwd1_sel_i, rf.rs1_data, exec_fwd_i, wb_data_i);
    assign fwd2 = pick_source(fwd2_sel_i, rf.rs2_data, exec_fwd_i, wb_data_i);

    assign sel_pc  = (opsel_i == OPSEL_PC) || (opsel_i == OPSEL_PC_IMM);
    assign sel_imm = (opsel_i == OPSEL_IMM) || (opsel_i == OPSEL_PC_IMM);

    assign val1_o       = sel_pc ? {pc_i, 1'b0} : fwd1;
    assign val2_o       = sel_imm ? imm_i : fwd2;
    assign store_data_o = fwd2; // Store data survives the immediate on val2

    // Flags always on the register operands, never on pc or imm
    assign cmp_o = {$signed(fwd1) < $signed(fwd2), fwd1 < fwd2, fwd1 == fwd2};

endmodule

// ==== regfile/register_file.sv ====
// 32 x 32 integer register file with two combinational reads and one synchronous write
`timescale 1ns/1ps

module register_file (
    input  logic                  clk_i,
    input  logic                  rst_i,
    regfile_read_if.regfile       rd_port,
    input  decode_pkg::reg_addr_t wr_addr_i,
    input  decode_pkg::word_t     wr_data_i,
    input  logic                  wr_en_i
);
    import decode_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin // x0 ignores writes
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Old value on a same-cycle write, writeback bypass is done by forwarding
    assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
    assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

endmodule

// ==== decode/imm_gen.sv ====
// Builds the sign-extended RV32I immediate, format chosen from the major opcode
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::instr_t instr_i,
    output decode_pkg::word_t  imm_o
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[31]; // Sign bit sits at bit 31 in every format

    always_comb begin
        case (instr_i[6:2])
            OPC_STORE: begin // S
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin // B, halfword offset
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin // J, halfword offset
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin // U
                imm_o = {instr_i[31:12], 12'b0};
            end
            // I format: OP-IMM, LOAD, JALR and every other opcode
            default: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
        endcase
    end

endmodule

// ==== decode/instr_decoder.sv ====
// Combinational RV32I decoder producing the execute operation code and operand selection
`timescale 1ns/1ps

module instr_decoder (
    input  decode_pkg::instr_t instr_i,
    output decode_pkg::op_e    op_o,
    output decode_pkg::opsel_e opsel_o
);
    import decode_pkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    opsel_e     sel;

    assign opcode  = instr_i[6:2];
    assign funct3  = instr_i[14:12];
    assign f7_zero = (instr_i[31:25] == 7'b0000000);
    assign f7_alt  = (instr_i[31:25] == 7'b0100000); // SUB, SRA, SRAI

    always_comb begin
        op_o = OP_ILLEGAL;
        sel  = OPSEL_REG;
        if (instr_i[1:0] == 2'b11) begin // Compressed encodings are not supported
            case (opcode)
                OPC_OP: begin
                    sel = OPSEL_REG;
                    case (funct3)
                        3'b000: op_o = f7_zero ? OP_ADD : (f7_alt ? OP_SUB : OP_ILLEGAL);
                        3'b001: op_o = f7_zero ? OP_SLL : OP_ILLEGAL;
                        3'b010: op_o = f7_zero ? OP_SLT : OP_ILLEGAL;
                        3'b011: op_o = f7_zero ? OP_SLTU : OP_ILLEGAL;
                        3'b100: op_o = f7_zero ? OP_XOR : OP_ILLEGAL;
                        3'b101: op_o = f7_zero ? OP_SRL : (f7_alt ? OP_SRA : OP_ILLEGAL);
                        3'b110: op_o = f7_zero ? OP_OR : OP_ILLEGAL;
                        3'b111: op_o = f7_zero ? OP_AND : OP_ILLEGAL;
                    endcase
                end
                OPC_OP_IMM: begin
                    sel = OPSEL_IMM;
                    case (funct3)
                        3'b000: op_o = OP_ADD;
                        3'b001: op_o = f7_zero ? OP_SLL : OP_ILLEGAL; // Shift amount in imm[4:0]
                        3'b010: op_o = OP_SLT;
                        3'b011: op_o = OP_SLTU;
                        3'b100: op_o = OP_XOR;
                        3'b101: op_o = f7_zero ? OP_SRL : (f7_alt ? OP_SRA : OP_ILLEGAL);
                        3'b110: op_o = OP_OR;
                        3'b111: op_o = OP_AND;
                    endcase
                end
                OPC_LOAD: begin
                    sel = OPSEL_IMM;
                    case (funct3)
                        3'b000:  op_o = OP_LB;
                        3'b001:  op_o = OP_LH;
                        3'b010:  op_o = OP_LW;
                        3'b100:  op_o = OP_LBU;
                        3'b101:  op_o = OP_LHU;
                        default: op_o = OP_ILLEGAL;
                    endcase
                end
                OPC_STORE: begin
                    sel = OPSEL_IMM;
                    case (funct3)
                        3'b000:  op_o = OP_SB;
                        3'b001:  op_o = OP_SH;
                        3'b010:  op_o = OP_SW;
                        default: op_o = OP_ILLEGAL;
                    endcase
                end
                OPC_BRANCH: begin
                    sel = OPSEL_PC_IMM; // Target computed in execute, flags come from here
                    case (funct3)
                        3'b000:  op_o = OP_BEQ;
                        3'b001:  op_o = OP_BNE;
                        3'b100:  op_o = OP_BLT;
                        3'b101:  op_o = OP_BGE;
                        3'b110:  op_o = OP_BLTU;
                        3'b111:  op_o = OP_BGEU;
                        default: op_o = OP_ILLEGAL;
                    endcase
                end
                OPC_JALR: begin
                    sel  = OPSEL_IMM;
                    op_o = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
                end
                OPC_JAL: begin
                    sel  = OPSEL_PC_IMM;
                    op_o = OP_JAL;
                end
                OPC_LUI: begin
                    sel  = OPSEL_IMM;
                    op_o = OP_LUI;
                end
                OPC_AUIPC: begin
                    sel  = OPSEL_PC_IMM;
                    op_o = OP_AUIPC;
                end
                default: op_o = OP_ILLEGAL;
            endcase
        end
        opsel_o = (op_o == OP_ILLEGAL) ? OPSEL_REG : sel;
    end

endmodule

// ==== common/regfile_read_if.sv ====
// Two combinational register-file read ports between the operand stage and the register file
`timescale 1ns/1ps

interface regfile_read_if;
    import decode_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // Operand side drives addresses, data comes back in the same cycle
    modport client (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport regfile (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

// ==== common/decode_pkg.sv ====
// Widths, major opcodes and enums for the decode stage; every RTL file imports what it needs
package decode_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [31:0]                 instr_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [XLEN-1:1]             pc_t;       // Halfword aligned, bit 0 implied
    typedef logic [2:0]                  cmp_flags_t; // {lt, ltu, eq}

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;

    // Operation code handed to execute; immediate ALU forms share the register codes
    typedef enum logic [4:0] {
        OP_NOP = 5'd0,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_ILLEGAL
    } op_e;

    typedef enum logic [1:0] {
        OPSEL_REG,    // rs1, rs2
        OPSEL_IMM,    // rs1, imm
        OPSEL_PC,     // pc, rs2
        OPSEL_PC_IMM  // pc, imm
    } opsel_e;

    // Code 3 is spare and treated as FWD_NONE
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EXEC = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

endpackage
